/* logic/pixel_store_pkg.sv */
// Pixel store shared definitions
`default_nettype none

package pixel_store_pkg;

    // Default geometry of the store
    localparam int DEFAULT_ADDR_W = 10;
    localparam int DEFAULT_DATA_W = 24;

    // Host operation code
    typedef logic [1:0] op_t;

    localparam op_t OP_READ  = 2'd0;
    localparam op_t OP_WRITE = 2'd1;
    localparam op_t OP_CLEAR = 2'd2;
    // Code 3 is reserved and behaves as a read

endpackage

`default_nettype wire

/* logic/ram_port_if.sv */
// RAM write and read port bundle
`timescale 1ns/100ps
`default_nettype none

interface ram_port_if #(
    parameter int ADDR_W = pixel_store_pkg::DEFAULT_ADDR_W,
    parameter int DATA_W = pixel_store_pkg::DEFAULT_DATA_W
) ();

    // Write side
    logic              write_en;
    logic [ADDR_W-1:0] write_addr;
    logic [DATA_W-1:0] data_in;

    // Read side
    logic [ADDR_W-1:0] read_addr;
    logic [DATA_W-1:0] data_out;

    modport controller (
        output write_en,
        output write_addr,
        output data_in,
        output read_addr,
        input  data_out
    );

    modport memory (
        input  write_en,
        input  write_addr,
        input  data_in,
        input  read_addr,
        output data_out
    );

endinterface

`default_nettype wire

/* logic/synchronous_ram.sv */
// Simple dual-port synchronous RAM
`timescale 1ns/100ps
`default_nettype none

module synchronous_ram #(
    parameter int ADDR_W = pixel_store_pkg::DEFAULT_ADDR_W,
    parameter int DATA_W = pixel_store_pkg::DEFAULT_DATA_W
) (
    input  logic     clk,
    ram_port_if.memory mem
);

    localparam int DEPTH = 1 << ADDR_W;

    // Word storage
    logic [DATA_W-1:0] storage [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (mem.write_en) begin
            storage[mem.write_addr] <= mem.data_in;
        end
    end

    // Registered read with one cycle of latency
    // A same-cycle write to read_addr is not yet visible, so the old word comes out
    always_ff @(posedge clk) begin
        mem.data_out <= storage[mem.read_addr];
    end

endmodule

`default_nettype wire

/* logic/clear_sweeper.sv */
// Clear sweep address counter
`timescale 1ns/100ps
`default_nettype none

module clear_sweeper #(
    parameter int ADDR_W = pixel_store_pkg::DEFAULT_ADDR_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              enable,
    output logic [ADDR_W-1:0] addr,
    output logic              last
);

    // Final location of the store
    localparam logic [ADDR_W-1:0] LAST_ADDR = {ADDR_W{1'b1}};

    logic [ADDR_W-1:0] count;

    // Start loads zero and wins over enable
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= '0;
        end else if (enable) begin
            count <= count + 1'b1;
        end
    end

    assign addr = count;

    // Flags the all-ones address so the controller can stop the sweep
    assign last = (count == LAST_ADDR);

endmodule

`default_nettype wire

/* logic/access_controller.sv */
// Host handshake and RAM access control
`timescale 1ns/100ps
`default_nettype none

module access_controller #(
    parameter int ADDR_W = pixel_store_pkg::DEFAULT_ADDR_W,
    parameter int DATA_W = pixel_store_pkg::DEFAULT_DATA_W
) (
    input  logic                 clk,
    input  logic                 rst,

    // Host side
    input  logic                 req,
    input  pixel_store_pkg::op_t op,
    input  logic [ADDR_W-1:0]    addr,
    input  logic [DATA_W-1:0]    wdata,
    output logic                 ack,
    output logic [DATA_W-1:0]    rdata,
    output logic                 ready,

    // Sweeper control
    output logic                 sweep_start,
    output logic                 sweep_enable,
    input  logic [ADDR_W-1:0]    sweep_addr,
    input  logic                 sweep_last,

    // RAM port
    ram_port_if.controller       ram
);

    import pixel_store_pkg::*;

    typedef enum logic [2:0] {
        RESET_SWEEP,
        IDLE,
        ACCESS,
        RESPOND,
        SWEEP,
        RELEASE
    } state_t;

    state_t state;

    // High once the sweeper has been loaded and zeros are being written
    logic sweep_live;

    // Latched request
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    op_t               op_q;

    logic sweeping;
    logic sweep_write;
    logic host_write;

    assign sweeping = (state == RESET_SWEEP) || (state == SWEEP);

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RESET_SWEEP;
            sweep_live <= 1'b0;
            ack        <= 1'b0;
            addr_q     <= '0;
        end else begin
            case (state)
                RESET_SWEEP, SWEEP: begin
                    if (!sweep_live) begin
                        // First cycle only loads the sweeper
                        sweep_live <= 1'b1;
                    end else if (sweep_last) begin
                        sweep_live <= 1'b0;
                        if (state == SWEEP) begin
                            // Host clear completes with an ack
                            ack   <= 1'b1;
                            state <= RELEASE;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end

                IDLE: begin
                    if (req) begin
                        addr_q <= addr;
                        if (op == OP_CLEAR) begin
                            state <= SWEEP;
                        end else begin
                            state <= ACCESS;
                        end
                    end
                end

                // RAM write lands or read data is registered here
                ACCESS: begin
                    state <= RESPOND;
                end

                RESPOND: begin
                    ack   <= 1'b1;
                    state <= RELEASE;
                end

                // Hold ack until the host lets go of req
                RELEASE: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if ((state == IDLE) && req) begin
            op_q    <= op;
            wdata_q <= wdata;
        end
    end

    // Sweeper handshake
    assign sweep_start  = sweeping && !sweep_live;
    assign sweep_write  = sweeping && sweep_live;
    assign sweep_enable = sweep_write;

    // Reserved code 3 falls through as a read
    assign host_write = (state == ACCESS) && (op_q == OP_WRITE);

    // RAM write port takes zeros from the sweeper outside ACCESS
    assign ram.write_en   = sweep_write || host_write;
    assign ram.write_addr = (state == ACCESS) ? addr_q : sweep_addr;
    assign ram.data_in    = (state == ACCESS) ? wdata_q : '0;

    // Read address stays on the latched request through RELEASE
    assign ram.read_addr = addr_q;
    assign rdata         = ram.data_out;

    assign ready = !sweeping;

endmodule

`default_nettype wire

/* logic/pixel_store.sv */
// Pixel store top level
`timescale 1ns/100ps
`default_nettype none

module pixel_store #(
    parameter int ADDR_W = pixel_store_pkg::DEFAULT_ADDR_W,
    parameter int DATA_W = pixel_store_pkg::DEFAULT_DATA_W
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  pixel_store_pkg::op_t op,
    input  logic [ADDR_W-1:0]    addr,
    input  logic [DATA_W-1:0]    wdata,
    output logic                 ack,
    output logic [DATA_W-1:0]    rdata,
    output logic                 ready
);

    // Controller to sweeper
    logic              sweep_start;
    logic              sweep_enable;
    logic [ADDR_W-1:0] sweep_addr;
    logic              sweep_last;

    // Controller to RAM
    ram_port_if #(
        .ADDR_W(ADDR_W),
        .DATA_W(DATA_W)
    ) ram_port ();

    access_controller #(
        .ADDR_W(ADDR_W),
        .DATA_W(DATA_W)
    ) i_access_controller (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .rdata       (rdata),
        .ready       (ready),
        .sweep_start (sweep_start),
        .sweep_enable(sweep_enable),
        .sweep_addr  (sweep_addr),
        .sweep_last  (sweep_last),
        .ram         (ram_port)
    );

    clear_sweeper #(
        .ADDR_W(ADDR_W)
    ) i_clear_sweeper (
        .clk   (clk),
        .rst   (rst),
        .start (sweep_start),
        .enable(sweep_enable),
        .addr  (sweep_addr),
        .last  (sweep_last)
    );

    synchronous_ram #(
        .ADDR_W(ADDR_W),
        .DATA_W(DATA_W)
    ) i_synchronous_ram (
        .clk(clk),
        .mem(ram_port)
    );

endmodule

`default_nettype wire

/* verification/synchronous_ram_assertions.sv */
// RAM reference checker
`timescale 1ns/100ps
`default_nettype none

module synchronous_ram_assertions #(
    parameter int ADDR_W = pixel_store_pkg::DEFAULT_ADDR_W,
    parameter int DATA_W = pixel_store_pkg::DEFAULT_DATA_W
) (
    input logic              clk,
    input logic              write_en,
    input logic [ADDR_W-1:0] write_addr,
    input logic [DATA_W-1:0] data_in,
    input logic [ADDR_W-1:0] read_addr,
    input logic [DATA_W-1:0] data_out
);

    localparam int DEPTH = 1 << ADDR_W;

    // Reference copy of the RAM and a written flag per word
    logic [DATA_W-1:0] ref_mem [DEPTH];
    logic [DEPTH-1:0]  ref_valid = '0;

    // Set once the controller drives known values
    logic armed = 1'b0;

    // Word that data_out should show in the current cycle
    logic              exp_valid = 1'b0;
    logic [DATA_W-1:0] exp_word;

    // Failed assertions so far, read by the testbench
    int fail_count = 0;

    always @(posedge clk) begin
        armed     <= armed || (!$isunknown(write_en) && !$isunknown(read_addr));
        exp_valid <= armed && ref_valid[read_addr];
        exp_word  <= ref_mem[read_addr];
        if (armed && write_en) begin
            ref_mem[write_addr]   <= data_in;
            ref_valid[write_addr] <= 1'b1;
        end
    end

    inputs_known: assert property (@(posedge clk)
        armed |-> !$isunknown({write_en, read_addr})
                  && (!write_en || !$isunknown({write_addr, data_in})))
        else begin
            $error("RAM input is unknown");
            fail_count++;
        end

    read_matches_model: assert property (@(posedge clk)
        exp_valid |-> (data_out == exp_word))
        else begin
            $error("RAM read does not match the reference word");
            fail_count++;
        end

    read_after_write: assert property (@(posedge clk)
        (armed && write_en) ##1 (read_addr == $past(write_addr))
        |=> (data_out == $past(data_in, 2)))
        else begin
            $error("RAM read after write returned a stale word");
            fail_count++;
        end

    // Same address and no write to it means the output holds
    output_stable: assert property (@(posedge clk)
        (exp_valid && $stable(read_addr)
         && !($past(write_en) && ($past(write_addr) == $past(read_addr))))
        |=> $stable(data_out))
        else begin
            $error("RAM data_out changed without cause");
            fail_count++;
        end

endmodule

bind synchronous_ram synchronous_ram_assertions #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
) i_synchronous_ram_assertions (
    .clk       (clk),
    .write_en  (mem.write_en),
    .write_addr(mem.write_addr),
    .data_in   (mem.data_in),
    .read_addr (mem.read_addr),
    .data_out  (mem.data_out)
);

`default_nettype wire

/* verification/pixel_store_tb.sv */
// Pixel store directed testbench
`timescale 1ns/100ps
`default_nettype none

module pixel_store_tb;

    import pixel_store_pkg::*;

    localparam int ADDR_W         = DEFAULT_ADDR_W;
    localparam int DATA_W         = DEFAULT_DATA_W;
    localparam int DEPTH          = 1 << ADDR_W;
    localparam int CLK_PERIOD     = 8;
    localparam int TIMEOUT_CYCLES = 20000;

    logic              clk = 1'b0;
    logic              rst;
    logic              req;
    op_t               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              ack;
    logic [DATA_W-1:0] rdata;
    logic              ready;

    // Expected contents of the store
    logic [DATA_W-1:0] model_mem [DEPTH];

    logic [31:0] lcg_state = 32'd11044;
    int          cycle_count = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    pixel_store i_pixel_store (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .op   (op),
        .addr (addr),
        .wdata(wdata),
        .ack  (ack),
        .rdata(rdata),
        .ready(ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [ADDR_W-1:0] random_addr();
        logic [31:0] r;
        r = lcg_next();
        return r[31 -: ADDR_W];
    endfunction

    function automatic logic [DATA_W-1:0] random_word();
        logic [31:0] r;
        r = lcg_next();
        return r[31 -: DATA_W];
    endfunction

    // Lowest and highest address first, then random ones
    function automatic logic [ADDR_W-1:0] pick_addr(input int index);
        if (index == 0) begin
            return '0;
        end else if (index == 1) begin
            return '1;
        end
        return random_addr();
    endfunction

    task automatic report_mismatch(input string test_name, input logic [DATA_W-1:0] expected,
                                   input logic [DATA_W-1:0] actual);
        $display("MISMATCH %s: expected %06h, actual %06h", test_name, expected, actual);
        test_errors++;
    endtask

    task automatic report_error(input string test_name, input string what);
        $display("ERROR %s: %s", test_name, what);
        test_errors++;
    endtask

    task automatic finish_test(input string test_name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic send_request(input op_t t_op, input logic [ADDR_W-1:0] t_addr,
                                input logic [DATA_W-1:0] t_wdata);
        @(posedge clk);
        req   <= 1'b1;
        op    <= t_op;
        addr  <= t_addr;
        wdata <= t_wdata;
    endtask

    task automatic wait_for_ack();
        do begin
            @(negedge clk);
        end while (ack !== 1'b1);
    endtask

    task automatic drop_request();
        @(posedge clk);
        req <= 1'b0;
        do begin
            @(negedge clk);
        end while (ack !== 1'b0);
    endtask

    // One complete four-phase handshake
    task automatic host_transfer(input op_t t_op, input logic [ADDR_W-1:0] t_addr,
                                 input logic [DATA_W-1:0] t_wdata,
                                 output logic [DATA_W-1:0] t_rdata);
        send_request(t_op, t_addr, t_wdata);
        wait_for_ack();
        t_rdata = rdata;
        drop_request();
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] unused;
        host_transfer(OP_WRITE, a, d, unused);
        model_mem[a] = d;
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
        host_transfer(OP_READ, a, '0, d);
    endtask

    task automatic test_reset_sweep();
        int wait_cycles;
        wait_cycles = 0;
        repeat (4) begin
            @(negedge clk);
            if (ack !== 1'b0 || ready !== 1'b0) begin
                report_error("reset_sweep", "ack or ready high during reset");
            end
        end
        // Reset is released on the fifth edge
        @(posedge clk);
        rst <= 1'b0;
        while (ready !== 1'b1) begin
            @(negedge clk);
            wait_cycles++;
            if (ack !== 1'b0) begin
                report_error("reset_sweep", "ack high during the self clear");
            end
            if (wait_cycles > 1100) begin
                report_error("reset_sweep", "ready did not rise within 1100 cycles");
                break;
            end
        end
        // Every location takes one cycle of the sweep
        if (wait_cycles < DEPTH) begin
            report_error("reset_sweep", "ready rose before the self clear could finish");
        end
        finish_test("reset_sweep");
    endtask

    task automatic test_cleared_contents();
        logic [DATA_W-1:0] got;
        for (int i = 0; i < 18; i++) begin
            read_word(pick_addr(i), got);
            if (got !== '0) begin
                report_mismatch("cleared_contents", '0, got);
            end
        end
        finish_test("cleared_contents");
    endtask

    task automatic test_write_read();
        logic [ADDR_W-1:0] addr_list [$];
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] got;
        for (int i = 0; i < 34; i++) begin
            a = pick_addr(i);
            write_word(a, random_word());
            addr_list.push_back(a);
        end
        foreach (addr_list[i]) begin
            read_word(addr_list[i], got);
            if (got !== model_mem[addr_list[i]]) begin
                report_mismatch("write_read", model_mem[addr_list[i]], got);
            end
        end
        finish_test("write_read");
    endtask

    task automatic test_overwrite();
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] first;
        logic [DATA_W-1:0] got;
        a     = random_addr();
        first = random_word();
        write_word(a, first);
        write_word(a, ~first);
        read_word(a, got);
        if (got !== ~first) begin
            report_mismatch("overwrite", ~first, got);
        end
        finish_test("overwrite");
    endtask

    task automatic test_clear_command();
        logic [ADDR_W-1:0] addr_list [$];
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] got;
        logic              seen_low;
        for (int i = 0; i < 6; i++) begin
            addr_list.push_back(random_addr());
            d    = random_word();
            d[0] = 1'b1;
            write_word(addr_list[i], d);
        end
        send_request(OP_CLEAR, '0, '0);
        seen_low = 1'b0;
        do begin
            @(negedge clk);
            if (ready === 1'b0) begin
                seen_low = 1'b1;
            end else if (seen_low && ack !== 1'b1) begin
                report_error("clear_command", "ready rose before the clear was acknowledged");
            end
        end while (ack !== 1'b1);
        if (!seen_low) begin
            report_error("clear_command", "ready never fell during the clear");
        end
        drop_request();
        foreach (model_mem[i]) begin
            model_mem[i] = '0;
        end
        foreach (addr_list[i]) begin
            read_word(addr_list[i], got);
            if (got !== model_mem[addr_list[i]]) begin
                report_mismatch("clear_command", model_mem[addr_list[i]], got);
            end
        end
        finish_test("clear_command");
    endtask

    task automatic test_handshake_hold();
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] held;
        int                fall_cycles;
        a    = random_addr();
        d    = random_word();
        d[0] = 1'b1;
        write_word(a, d);
        send_request(OP_READ, a, '0);
        wait_for_ack();
        held = rdata;
        if (held !== d) begin
            report_mismatch("handshake_hold", d, held);
        end
        // Host keeps req high well past the ack
        repeat (20) begin
            @(negedge clk);
            if (ack !== 1'b1) begin
                report_error("handshake_hold", "ack fell while req was still high");
            end
            if (rdata !== held) begin
                report_mismatch("handshake_hold", held, rdata);
            end
        end
        @(posedge clk);
        req <= 1'b0;
        fall_cycles = 0;
        do begin
            @(negedge clk);
            fall_cycles++;
        end while (ack !== 1'b0 && fall_cycles < 4);
        if (ack !== 1'b0) begin
            report_error("handshake_hold", "ack did not fall after req was dropped");
        end
        finish_test("handshake_hold");
    endtask

    // Run limit
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: run timed out after %0d cycles", cycle_count);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int assert_fails;
        rst   = 1'b1;
        req   = 1'b0;
        op    = OP_READ;
        addr  = '0;
        wdata = '0;
        foreach (model_mem[i]) begin
            model_mem[i] = '0;
        end
        test_reset_sweep();
        test_cleared_contents();
        test_write_read();
        test_overwrite();
        test_clear_command();
        test_handshake_hold();
        assert_fails = i_pixel_store.i_synchronous_ram.i_synchronous_ram_assertions.fail_count;
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, assert_fails);
        if (tests_failed == 0 && assert_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pixel_store.f */
logic/pixel_store_pkg.sv
logic/ram_port_if.sv
logic/synchronous_ram.sv
logic/clear_sweeper.sv
logic/access_controller.sv
logic/pixel_store.sv
verification/synchronous_ram_assertions.sv
verification/pixel_store_tb.sv

/* Bender.yml */
package:
  name: pixel_store

sources:
  - files:
      - logic/pixel_store_pkg.sv
      - logic/ram_port_if.sv
      - logic/synchronous_ram.sv
      - logic/clear_sweeper.sv
      - logic/access_controller.sv
      - logic/pixel_store.sv
  - target: test
    files:
      - verification/synchronous_ram_assertions.sv
      - verification/pixel_store_tb.sv
